/* list.f */
+incdir+verilog
verilog/led_matrix_pkg.sv
verilog/timeout.sv
verilog/frame_buffer.sv
verilog/pixel_select.sv
verilog/matrix_scan.sv
verilog/led_panel.sv
tb/led_panel_tb.sv

/* tb/led_panel_tb.sv */
`timescale 1ns/1ns

`include "led_matrix_macros.svh"

module led_panel_tb;

    localparam int DEPTH = 2 * `MATRIX_HALFHEIGHT * `MATRIX_WIDTH;
    localparam int TABLE_LEN = 8;
    // 17 rows so that the active row wraps once
    localparam int NUM_PLANES = `COLOUR_BITS * (`MATRIX_HALFHEIGHT + 1);
    localparam int IDLE_LIMIT = 2000;

    logic                        clk_in;
    logic                        reset;
    logic                        wr_en;
    led_matrix_pkg::pixel_addr_t wr_addr;
    led_matrix_pkg::pixel_word_u wr_data;
    logic                        r0, g0, b0, r1, g1, b1;
    logic                        clk_pixel;
    logic                        row_latch;
    logic                        output_enable;
    led_matrix_pkg::row_t        row_address_active;

    // panel model with red in the top six bits and blue in the bottom six
    logic [17:0] model [0:DEPTH-1];
    // entry is {address, red, green, blue, msb plane bits r g b}
    logic [31:0] write_table [0:TABLE_LEN-1];
    logic [31:0] seed;

    led_panel i_dut (
        .reset              (reset),
        .clk_in             (clk_in),
        .wr_en              (wr_en),
        .wr_addr            (wr_addr),
        .wr_data            (wr_data),
        .r0                 (r0),
        .g0                 (g0),
        .b0                 (b0),
        .r1                 (r1),
        .g1                 (g1),
        .b1                 (b1),
        .clk_pixel          (clk_pixel),
        .row_latch          (row_latch),
        .output_enable      (output_enable),
        .row_address_active (row_address_active)
    );

    always #10 clk_in = ~clk_in;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // one bit per channel for a given plane
    function automatic logic [2:0] plane_rgb(input logic [17:0] word, input int plane);
        return {word[2*`COLOUR_BITS + plane], word[`COLOUR_BITS + plane], word[plane]};
    endfunction

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s got %0h expected %0h",
                     $time, name, got, expected);
            $display("Checks failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        $display("Checks failed");
        $fatal(1, "wait timed out");
    endtask

    task automatic write_pixel(input logic [10:0] addr, input logic [17:0] data);
        @(posedge clk_in);
        wr_en       <= 1'b1;
        wr_addr     <= addr;
        wr_data.raw <= data;
        model[addr] = data;
    endtask

    // row 0 pixels at both ends and the middle of both halves
    task automatic load_write_table;
        write_table[0] = {11'h03f, 6'h3f, 6'h00, 6'h00, 3'b100};
        write_table[1] = {11'h43f, 6'h00, 6'h3f, 6'h00, 3'b010};
        write_table[2] = {11'h000, 6'h00, 6'h00, 6'h3f, 3'b001};
        write_table[3] = {11'h400, 6'h3f, 6'h3f, 6'h3f, 3'b111};
        write_table[4] = {11'h020, 6'h1f, 6'h1f, 6'h1f, 3'b000};
        write_table[5] = {11'h420, 6'h20, 6'h00, 6'h20, 3'b101};
        write_table[6] = {11'h011, 6'h2a, 6'h35, 6'h15, 3'b110};
        write_table[7] = {11'h411, 6'h15, 6'h2a, 6'h3f, 3'b011};
    endtask

    // follows the scan cycle by cycle on the falling edge
    task automatic follow_scan;
        int          latches;
        int          pix_cnt;
        int          oe_len;
        int          oe_expect;
        int          oe_checked;
        int          idle;
        int          plane;
        int          row;
        int          col;
        int          row_expect;
        logic        after_latch;
        logic        oe_on;
        logic [10:0] addr_top;
        logic [10:0] addr_bottom;

        latches     = 0;
        pix_cnt     = 0;
        oe_len      = 0;
        oe_expect   = 0;
        oe_checked  = 0;
        idle        = 0;
        row_expect  = 0;
        after_latch = 1'b0;
        oe_on       = 1'b0;
        while (oe_checked < NUM_PLANES) begin
            @(negedge clk_in);
            idle++;
            if (idle > IDLE_LIMIT) begin
                if (oe_on) begin
                    give_up("output_enable never went low");
                end else begin
                    give_up("row_latch never arrived");
                end
            end
            // pixel shift with the msb plane first
            if (clk_pixel) begin
                check("clk_pixel count within plane", pix_cnt < `MATRIX_WIDTH, 1);
                plane       = `COLOUR_BITS - 1 - (latches % `COLOUR_BITS);
                row         = (latches / `COLOUR_BITS) % `MATRIX_HALFHEIGHT;
                col         = `MATRIX_WIDTH - 1 - pix_cnt;
                addr_top    = {1'b0, row[3:0], col[5:0]};
                addr_bottom = {1'b1, row[3:0], col[5:0]};
                check("r0 g0 b0", {r0, g0, b0}, plane_rgb(model[addr_top], plane));
                check("r1 g1 b1", {r1, g1, b1}, plane_rgb(model[addr_bottom], plane));
                // first plane is the row 0 msb plane
                // also compare with the hand values
                if (latches == 0) begin
                    for (int i = 0; i < TABLE_LEN; i++) begin
                        if (write_table[i][31:21] == addr_top)
                            check("r0 g0 b0 table", {r0, g0, b0}, write_table[i][2:0]);
                        if (write_table[i][31:21] == addr_bottom)
                            check("r1 g1 b1 table", {r1, g1, b1}, write_table[i][2:0]);
                    end
                end
                pix_cnt++;
            end
            // cycle after a latch
            if (after_latch) begin
                check("row_latch width", row_latch, 0);
                check("output_enable after row_latch", output_enable, 1);
                check("row_address_active", row_address_active, row_expect);
                oe_len = 0;
                oe_on  = 1'b1;
            end
            if (oe_on) begin
                if (output_enable) begin
                    oe_len++;
                end else begin
                    check("output_enable width", oe_len, oe_expect);
                    oe_on = 1'b0;
                    oe_checked++;
                    idle = 0;
                end
            end
            if (row_latch) begin
                // previous enable period has ended by now
                check("output_enable at row_latch", output_enable, 0);
                check("clk_pixel cycles per plane", pix_cnt, `MATRIX_WIDTH);
                oe_expect  = `OE_BASE_CYCLES << (`COLOUR_BITS - 1 - (latches % `COLOUR_BITS));
                row_expect = (latches / `COLOUR_BITS) % `MATRIX_HALFHEIGHT;
                latches++;
                pix_cnt = 0;
                idle    = 0;
            end
            after_latch = row_latch;
        end
    endtask

    initial begin
        clk_in      = 1'b0;
        reset       = 1'b0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        load_write_table();

        // random fill first and table entries on top
        seed = 32'h30d2_8263;
        for (int a = 0; a < DEPTH; a++) begin
            seed = lcg_next(seed);
            write_pixel(11'(a), seed[31:14]);
        end
        for (int i = 0; i < TABLE_LEN; i++) begin
            write_pixel(write_table[i][31:21], write_table[i][20:3]);
        end
        @(posedge clk_in);
        wr_en <= 1'b0;

        // scan runs as soon as reset drops
        @(posedge clk_in);
        reset <= 1'b1;
        repeat (5) @(posedge clk_in);
        reset <= 1'b0;

        @(negedge clk_in);
        check("clk_pixel after reset", clk_pixel, 0);
        check("row_latch after reset", row_latch, 0);
        check("output_enable after reset", output_enable, 0);
        check("row_address_active after reset", row_address_active, 0);

        follow_scan();

        $display("All checks passed");
        $finish;
    end

endmodule

/* verilog/frame_buffer.sv */
`timescale 1ns/1ns

module frame_buffer (
    input  logic                        reset,
    input  logic                        clk_in,

    // write side, one word per cycle, no back-pressure
    input  logic                        wr_en,
    input  led_matrix_pkg::pixel_addr_t wr_addr,
    input  led_matrix_pkg::pixel_word_u wr_data,

    // read side for the scan, both halves at once
    input  led_matrix_pkg::pixel_addr_t rd_addr_top,
    input  led_matrix_pkg::pixel_addr_t rd_addr_bottom,
    output led_matrix_pkg::pixel_word_u rd_top,
    output led_matrix_pkg::pixel_word_u rd_bottom
);

    // whole panel, both halves, stored raw
    logic [$bits(led_matrix_pkg::pixel_word_u)-1:0]
        mem [0:(1 << $bits(led_matrix_pkg::pixel_addr_t))-1];

    // write port
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data.raw;
        end
    end

    // two read ports, one cycle latency
    // a same-cycle write to the read address returns the old word
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rd_top.raw    <= '0;
            rd_bottom.raw <= '0;
        end else begin
            rd_top.raw    <= mem[rd_addr_top];
            rd_bottom.raw <= mem[rd_addr_bottom];
        end
    end

endmodule

/* verilog/led_matrix_macros.svh */
`ifndef LED_MATRIX_MACROS_SVH
`define LED_MATRIX_MACROS_SVH

// panel geometry, one half is scanned in parallel with the other
`define MATRIX_WIDTH 64
`define MATRIX_HALFHEIGHT 16

// bits per colour, also the number of brightness planes
`define COLOUR_BITS 6

// width of the enable timer and the load counter
`define TIMER_BITS 10

// enable count below which the next plane may start shifting
`define OVERLAP_CYCLES 67

// enable width of the lsb plane, doubled for each higher plane
`define OE_BASE_CYCLES 23

`endif

/* verilog/led_matrix_pkg.sv */
`include "led_matrix_macros.svh"

package led_matrix_pkg;

    // column index within one row, 0 to 63
    typedef logic [$clog2(`MATRIX_WIDTH)-1:0] column_t;

    // row index within one half panel
    typedef logic [$clog2(`MATRIX_HALFHEIGHT)-1:0] row_t;

    // buffer address as {half, row, column}
    // half 0 is the top half, half 1 the bottom half
    typedef logic [$clog2(`MATRIX_WIDTH)+$clog2(`MATRIX_HALFHEIGHT):0] pixel_addr_t;

    // one stored pixel
    // raw view for the write port and the memory
    // rgb view for the plane bit selection
    typedef union packed {
        logic [3*`COLOUR_BITS-1:0] raw;
        struct packed {
            logic [`COLOUR_BITS-1:0] red;
            logic [`COLOUR_BITS-1:0] green;
            logic [`COLOUR_BITS-1:0] blue;
        } rgb;
    } pixel_word_u;

endpackage

/* verilog/led_panel.sv */
`timescale 1ns/1ns

`include "led_matrix_macros.svh"

module led_panel (
    input  logic                        reset,
    input  logic                        clk_in,

    // pixel write port
    input  logic                        wr_en,
    input  led_matrix_pkg::pixel_addr_t wr_addr,
    input  led_matrix_pkg::pixel_word_u wr_data,

    // hub75 pins
    output logic                        r0,
    output logic                        g0,
    output logic                        b0,
    output logic                        r1,
    output logic                        g1,
    output logic                        b1,
    output logic                        clk_pixel,
    output logic                        row_latch,
    output logic                        output_enable,
    output led_matrix_pkg::row_t        row_address_active
);

    led_matrix_pkg::column_t     column_address;
    led_matrix_pkg::row_t        row_address;
    logic [`COLOUR_BITS-1:0]     brightness_mask;
    led_matrix_pkg::pixel_addr_t rd_addr_top;
    led_matrix_pkg::pixel_addr_t rd_addr_bottom;
    led_matrix_pkg::pixel_word_u rd_top;
    led_matrix_pkg::pixel_word_u rd_bottom;

    // same row and column in both halves, half bit on top
    assign rd_addr_top    = {1'b0, row_address, column_address};
    assign rd_addr_bottom = {1'b1, row_address, column_address};

    frame_buffer u_frame_buffer (
        .reset          (reset),
        .clk_in         (clk_in),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .rd_addr_top    (rd_addr_top),
        .rd_addr_bottom (rd_addr_bottom),
        .rd_top         (rd_top),
        .rd_bottom      (rd_bottom)
    );

    matrix_scan u_matrix_scan (
        .reset              (reset),
        .clk_in             (clk_in),
        .column_address     (column_address),
        .row_address        (row_address),
        .row_address_active (row_address_active),
        .clk_pixel          (clk_pixel),
        .row_latch          (row_latch),
        .output_enable      (output_enable),
        .brightness_mask    (brightness_mask)
    );

    // pins valid in the same cycle as clk_pixel
    pixel_select u_pixel_select (
        .reset           (reset),
        .clk_in          (clk_in),
        .top             (rd_top),
        .bottom          (rd_bottom),
        .brightness_mask (brightness_mask),
        .r0              (r0),
        .g0              (g0),
        .b0              (b0),
        .r1              (r1),
        .g1              (g1),
        .b1              (b1)
    );

endmodule

/* verilog/matrix_scan.sv */
`timescale 1ns/1ns

`include "led_matrix_macros.svh"

module matrix_scan (
    input  logic                     reset,
    input  logic                     clk_in,

    // address of the column being read for shift-out
    output led_matrix_pkg::column_t  column_address,
    // row being shifted in and row currently lit
    output led_matrix_pkg::row_t     row_address,
    output led_matrix_pkg::row_t     row_address_active,

    output logic                     clk_pixel,
    output logic                     row_latch,
    output logic                     output_enable,

    // one-hot plane select for the row being shifted
    output logic [`COLOUR_BITS-1:0]  brightness_mask
);

    // two-stage history of state_advance
    logic [1:0] state;
    logic       state_advance;
    logic       load_start;
    // high while a plane is owed a shift-out
    // set at reset and by each latch
    logic       plane_pending;

    logic                   load_en;
    logic [`TIMER_BITS-1:0] load_count;

    // load_en delayed through the buffer and pin stages
    logic [2:0] load_dly;

    logic [`TIMER_BITS-1:0]  oe_cycles;
    logic [`TIMER_BITS-1:0]  oe_count;

    // next plane may shift while the current one is still lit
    assign state_advance = !output_enable || (oe_count < `TIMER_BITS'(`OVERLAP_CYCLES));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= 2'b00;
        end else begin
            state <= {state[0], state_advance && plane_pending};
        end
    end

    // rising edge of the qualified advance
    assign load_start = state[0] && !state[1];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            plane_pending <= 1'b1;
        end else if (row_latch) begin
            plane_pending <= 1'b1;
        end else if (load_start) begin
            plane_pending <= 1'b0;
        end
    end

    // 64 load cycles per plane
    timeout u_load_counter (
        .reset   (reset),
        .clk_in  (clk_in),
        .start   (load_start),
        .value   (`TIMER_BITS'(`MATRIX_WIDTH)),
        .counter (load_count),
        .running (load_en)
    );

    // count 64..1 maps to column 63..0
    assign column_address = led_matrix_pkg::column_t'(load_count[5:0] - 6'd1);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            load_dly  <= 3'b000;
            row_latch <= 1'b0;
        end else begin
            load_dly  <= {load_dly[1:0], load_en};
            // pulse once the pixel clock has been low for a cycle
            row_latch <= load_dly[2] && !load_dly[1];
        end
    end

    // lines up with the rgb pins two cycles after the load
    assign clk_pixel = load_dly[1];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            brightness_mask        <= {1'b1, {(`COLOUR_BITS-1){1'b0}}};
            row_address            <= '0;
            row_address_active     <= '0;
        end else if (row_latch) begin
            row_address_active     <= row_address;
            if (brightness_mask[0]) begin
                // wrap to the msb plane and move to the next row after the lsb plane
                brightness_mask <= {1'b1, {(`COLOUR_BITS-1){1'b0}}};
                row_address     <= row_address + 1'b1;
            end else begin
                brightness_mask <= brightness_mask >> 1;
            end
        end
    end

    // the plane being latched takes over as the active one
    // binary weighted enable width per plane
    always_comb begin
        oe_cycles = '0;
        for (int k = 0; k < `COLOUR_BITS; k++) begin
            if (brightness_mask[k]) begin
                oe_cycles = `TIMER_BITS'(`OE_BASE_CYCLES << k);
            end
        end
    end

    // enable period starts the cycle after the latch
    timeout u_enable_timer (
        .reset   (reset),
        .clk_in  (clk_in),
        .start   (row_latch),
        .value   (oe_cycles),
        .counter (oe_count),
        .running (output_enable)
    );

endmodule

/* verilog/pixel_select.sv */
`timescale 1ns/1ns

`include "led_matrix_macros.svh"

module pixel_select (
    input  logic                        reset,
    input  logic                        clk_in,

    // pixels read for the top and bottom halves
    input  led_matrix_pkg::pixel_word_u top,
    input  led_matrix_pkg::pixel_word_u bottom,

    // one-hot plane select from the scan
    input  logic [`COLOUR_BITS-1:0]     brightness_mask,

    // top half pins
    output logic                        r0,
    output logic                        g0,
    output logic                        b0,
    // bottom half pins
    output logic                        r1,
    output logic                        g1,
    output logic                        b1
);

    // mask delayed to match the buffer read latency
    logic [`COLOUR_BITS-1:0] mask_q;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            mask_q <= '0;
        end else begin
            mask_q <= brightness_mask;
        end
    end

    // pick one plane bit per channel and register onto the pins
    always_ff @(posedge clk_in) begin
        if (reset) begin
            r0 <= 1'b0;
            g0 <= 1'b0;
            b0 <= 1'b0;
            r1 <= 1'b0;
            g1 <= 1'b0;
            b1 <= 1'b0;
        end else begin
            r0 <= |(top.rgb.red & mask_q);
            g0 <= |(top.rgb.green & mask_q);
            b0 <= |(top.rgb.blue & mask_q);
            r1 <= |(bottom.rgb.red & mask_q);
            g1 <= |(bottom.rgb.green & mask_q);
            b1 <= |(bottom.rgb.blue & mask_q);
        end
    end

endmodule

/* verilog/timeout.sv */
`timescale 1ns/1ns

`include "led_matrix_macros.svh"

module timeout (
    input  logic                   reset,
    input  logic                   clk_in,

    // load request, ignored while a count is in progress
    input  logic                   start,
    input  logic [`TIMER_BITS-1:0] value,

    output logic [`TIMER_BITS-1:0] counter,
    output logic                   running
);

    // busy whenever the count has not reached zero
    assign running = (counter != '0);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start && !running) begin
            // idle, so take the new count
            counter <= value;
        end else if (running) begin
            counter <= counter - 1'b1;
        end
    end

endmodule
